// File: Bender.yml
package:
  name: tawas

sources:
  - hdl/tawas_pkg.sv
  - hdl/tawas_fetch.sv
  - hdl/tawas_regfile.sv
  - hdl/tawas_au.sv
  - hdl/tawas_ls.sv
  - hdl/tawas_raccoon.sv
  - hdl/tawas.sv
  - target: simulation
    files:
      - testbench/tawas_tb.sv

// File: hdl/tawas.sv
// Core top level joining fetch, register file, arithmetic, load/store and bus bridge
`timescale 1ns/1ps

module tawas import tawas_pkg::*; #(
  parameter word_t racc_base = 32'h8000_0000,
  parameter pc_t slice_pc_stride = 24'h40
) (
  input  logic       clk,
  input  logic       rst,
  output logic       ics,
  output pc_t        iaddr,
  input  word_t      idata,
  output logic       dcs,
  output logic       dwr,
  output mask_t      dmask,
  output word_t      daddr,
  output word_t      dout,
  input  word_t      din,
  output logic       wb_cyc,
  output logic       wb_stb,
  output logic       wb_we,
  output word_t      wb_adr,
  output mask_t      wb_sel,
  output word_t      wb_wdata,
  input  word_t      wb_rdata,
  input  logic       wb_ack,
  output logic [3:0] halted
);

  // Decoded instruction of the slice in its execute cycle
  slice_t slice;
  pc_t pc_exec;
  opcode_e op;
  reg_sel_t ra_sel;
  reg_sel_t rb_sel;
  reg_sel_t rc_sel;
  word_t imm;
  logic au_op_vld;
  logic ls_op_vld;

  // Operands read from the decoding slice's bank
  word_t au_ra;
  word_t au_rb;
  word_t ls_ptr;
  word_t ls_store;

  // AU writeback and branch redirect
  logic au_rc_vld;
  reg_sel_t au_rc_sel;
  word_t au_rc;
  logic branch_taken;
  pc_t branch_pc;

  // Local load return
  logic ls_load_vld;
  slice_t ls_load_slice;
  reg_sel_t ls_load_sel;
  word_t ls_load;

  // Requests handed to the bridge, and its stall and load return
  logic racc_req;
  slice_t racc_slice;
  logic racc_we;
  word_t racc_adr;
  mask_t racc_sel;
  word_t racc_wdata;
  reg_sel_t racc_rc_sel;
  logic [3:0] raccoon_stall;
  logic raccoon_load_vld;
  slice_t raccoon_load_slice;
  reg_sel_t raccoon_load_sel;
  word_t raccoon_load;

  tawas_fetch #(.slice_pc_stride(slice_pc_stride)) tawas_fetch (.*);

  // The load/store pointer and store data use the same register fields as the AU operands
  tawas_regfile tawas_regfile (
    .ls_ptr_sel(ra_sel),
    .ls_store_sel(rb_sel),
    .*
  );

  tawas_au tawas_au (.*);

  tawas_ls #(.racc_base(racc_base)) tawas_ls (.*);

  tawas_raccoon tawas_raccoon (.*);

endmodule

// File: hdl/tawas_au.sv
// Arithmetic unit for register and immediate operations, plus branch resolution
`timescale 1ns/1ps

module tawas_au import tawas_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     au_op_vld,
  input  opcode_e  op,
  input  pc_t      pc_exec,
  input  reg_sel_t rc_sel,
  input  word_t    imm,
  input  word_t    au_ra,
  input  word_t    au_rb,
  output logic     au_rc_vld,
  output reg_sel_t au_rc_sel,
  output word_t    au_rc,
  output logic     branch_taken,
  output pc_t      branch_pc
);

  word_t result;
  logic writes_rc;

  always_comb begin
    case (op)
      op_add: begin
        result = au_ra + au_rb;
      end
      op_sub: begin
        result = au_ra - au_rb;
      end
      op_and: begin
        result = au_ra & au_rb;
      end
      op_or: begin
        result = au_ra | au_rb;
      end
      op_xor: begin
        result = au_ra ^ au_rb;
      end
      op_addi: begin
        result = au_ra + imm;
      end
      // Upper immediate fills the top half and clears the bottom
      op_lui: begin
        result = {imm[15:0], 16'h0000};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // Branches have no destination register
  assign writes_rc = au_op_vld && (op inside {op_add, op_sub, op_and, op_or, op_xor,
                                              op_addi, op_lui});

  always_ff @(posedge clk) begin
    if (rst) begin
      au_rc_vld <= 1'b0;
    end else begin
      au_rc_vld <= writes_rc;
    end
  end

  always_ff @(posedge clk) begin
    au_rc_sel <= rc_sel;
    au_rc <= result;
  end

  // BZ offsets are relative to the branch itself, JMP takes an absolute word address
  assign branch_taken = au_op_vld && ((op == op_bz && au_ra == '0) || op == op_jmp);
  assign branch_pc = (op == op_jmp) ? pc_t'(imm[15:0]) : pc_exec + pc_t'(imm);

endmodule

// File: hdl/tawas_fetch.sv
// Slice rotation, per-slice program counters, halt mask, instruction decode and issue
`timescale 1ns/1ps

module tawas_fetch import tawas_pkg::*; #(
  parameter pc_t slice_pc_stride = 24'h40
) (
  input  logic         clk,
  input  logic         rst,
  output logic         ics,
  output pc_t          iaddr,
  input  word_t        idata,
  input  logic [3:0]   raccoon_stall,
  input  logic         branch_taken,
  input  pc_t          branch_pc,
  output slice_t       slice,
  output pc_t          pc_exec,
  output opcode_e      op,
  output reg_sel_t     ra_sel,
  output reg_sel_t     rb_sel,
  output reg_sel_t     rc_sel,
  output word_t        imm,
  output logic         au_op_vld,
  output logic         ls_op_vld,
  output logic [3:0]   halted
);

  // Slice that will present its pc to the instruction memory in the next cycle
  slice_t cnt;
  pc_t pc [num_slices];
  logic issue;
  logic dec_vld;

  // A slice gives up its slot while it waits on the bus or after it has halted
  assign issue = !halted[cnt] && !raccoon_stall[cnt];

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
      ics <= 1'b0;
      dec_vld <= 1'b0;
      halted <= '0;
      for (int i = 0; i < num_slices; i++) begin
        pc[i] <= pc_t'(i) * slice_pc_stride;
      end
    end else begin
      cnt <= cnt + slice_t'(1);
      ics <= issue;
      dec_vld <= ics;
      if (issue) begin
        pc[cnt] <= pc[cnt] + pc_t'(1);
      end
      // The decoding slice is two behind cnt, so these never hit the slice being issued
      if (branch_taken) begin
        pc[slice] <= branch_pc;
      end
      if (dec_vld && op == op_halt) begin
        halted[slice] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    iaddr <= pc[cnt];
    pc_exec <= iaddr;
  end

  // Decode happens in the cycle the instruction word returns
  assign slice = cnt - slice_t'(2);
  assign op = opcode_e'(idata[31:28]);
  assign rc_sel = idata[26:24];
  assign ra_sel = idata[22:20];
  assign rb_sel = idata[18:16];
  assign imm = {{16{idata[15]}}, idata[15:0]};

  assign au_op_vld = dec_vld && (op inside {op_add, op_sub, op_and, op_or, op_xor,
                                            op_addi, op_lui, op_bz, op_jmp});
  assign ls_op_vld = dec_vld && (op inside {op_ld, op_st, op_stb});

  // A halted slice stays out of the instruction memory until reset
  assert property (@(posedge clk) disable iff (rst) ics |-> !halted[cnt - slice_t'(1)])
    else $error("fetch issued for a halted slice");

endmodule

// File: hdl/tawas_ls.sv
// Load/store address and byte mask generation, local memory strobes and load return
`timescale 1ns/1ps

module tawas_ls import tawas_pkg::*; #(
  parameter word_t racc_base = 32'h8000_0000
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     ls_op_vld,
  input  opcode_e  op,
  input  slice_t   slice,
  input  reg_sel_t rc_sel,
  input  word_t    imm,
  input  word_t    ls_ptr,
  input  word_t    ls_store,
  output logic     dcs,
  output logic     dwr,
  output mask_t    dmask,
  output word_t    daddr,
  output word_t    dout,
  input  word_t    din,
  output logic     ls_load_vld,
  output slice_t   ls_load_slice,
  output reg_sel_t ls_load_sel,
  output word_t    ls_load,
  output logic     racc_req,
  output slice_t   racc_slice,
  output logic     racc_we,
  output word_t    racc_adr,
  output mask_t    racc_sel,
  output word_t    racc_wdata,
  output reg_sel_t racc_rc_sel
);

  word_t addr;
  mask_t mask;
  word_t wdata;
  logic is_store;
  logic is_racc;
  logic we_q;
  reg_sel_t rc_q;

  assign addr = ls_ptr + imm;
  assign is_store = (op == op_st) || (op == op_stb);
  assign is_racc = (addr >= racc_base);

  // A byte store repeats the byte on every lane and enables only the addressed one
  assign mask = (op == op_stb) ? mask_t'(1) << addr[1:0] : 4'hf;
  assign wdata = (op == op_stb) ? {4{ls_store[7:0]}} : ls_store;

  always_ff @(posedge clk) begin
    if (rst) begin
      dcs <= 1'b0;
      racc_req <= 1'b0;
      we_q <= 1'b0;
      ls_load_vld <= 1'b0;
    end else begin
      dcs <= ls_op_vld && !is_racc;
      racc_req <= ls_op_vld && is_racc;
      we_q <= ls_op_vld && is_store;
      // Local read data comes back one cycle after the strobe
      ls_load_vld <= dcs && !we_q;
    end
  end

  // Local and bridge accesses share one set of payload registers
  always_ff @(posedge clk) begin
    daddr <= addr;
    dmask <= mask;
    dout <= wdata;
    racc_slice <= slice;
    rc_q <= rc_sel;
    ls_load_slice <= racc_slice;
    ls_load_sel <= rc_q;
  end

  assign dwr = dcs && we_q;
  assign ls_load = din;
  assign racc_we = we_q;
  assign racc_adr = daddr;
  assign racc_sel = dmask;
  assign racc_wdata = dout;
  assign racc_rc_sel = rc_q;

endmodule

// File: hdl/tawas_pkg.sv
// Shared widths, slice and register types, opcode encoding and raccoon FSM states
package tawas_pkg;

  // Number of hardware threads (slices) and registers in each slice's bank
  localparam int num_slices = 4;
  localparam int num_regs = 8;

  // One data word, as held in a register or moved over a data port
  typedef logic [31:0] word_t;

  // Instruction addresses count 32-bit words, not bytes
  typedef logic [23:0] pc_t;

  // Index of a slice within the round-robin rotation
  typedef logic [1:0] slice_t;

  // Register number inside one slice's bank
  // Register r0 always reads zero
  typedef logic [2:0] reg_sel_t;

  // One bit per byte lane of a data word
  typedef logic [3:0] mask_t;

  // Opcode field, bits 31:28 of the instruction word
  // Values that are not listed here execute as no-ops
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_addi = 4'd5,
    op_lui  = 4'd6,
    op_ld   = 4'd7,
    op_st   = 4'd8,
    op_stb  = 4'd9,
    op_bz   = 4'd10,
    op_jmp  = 4'd11,
    op_halt = 4'd15
  } opcode_e;

  // The bridge FSM waits for a queued request, runs one bus cycle, then idles for a cycle
  typedef enum logic [1:0] {
    racc_idle = 2'd0,
    racc_bus  = 2'd1,
    racc_done = 2'd2
  } racc_state_e;

endpackage

// File: hdl/tawas_raccoon.sv
// Bus bridge with per-slice request slots, round-robin Wishbone classic master and stalls
`timescale 1ns/1ps

module tawas_raccoon import tawas_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       racc_req,
  input  slice_t     racc_slice,
  input  logic       racc_we,
  input  word_t      racc_adr,
  input  mask_t      racc_sel,
  input  word_t      racc_wdata,
  input  reg_sel_t   racc_rc_sel,
  output logic [3:0] raccoon_stall,
  output logic       raccoon_load_vld,
  output slice_t     raccoon_load_slice,
  output reg_sel_t   raccoon_load_sel,
  output word_t      raccoon_load,
  output logic       wb_cyc,
  output logic       wb_stb,
  output logic       wb_we,
  output word_t      wb_adr,
  output mask_t      wb_sel,
  output word_t      wb_wdata,
  input  word_t      wb_rdata,
  input  logic       wb_ack
);

  racc_state_e state;
  logic [3:0] slot_vld;
  logic [3:0] slot_we;
  word_t slot_adr [num_slices];
  mask_t slot_sel [num_slices];
  word_t slot_wdata [num_slices];
  reg_sel_t slot_rc [num_slices];
  slice_t rr;
  slice_t cur;
  slice_t pick;
  logic pick_vld;

  // The nearest full slot at or after rr wins, so the last match in this loop counts
  always_comb begin
    slice_t idx;
    pick = rr;
    pick_vld = 1'b0;
    for (int i = num_slices - 1; i >= 0; i--) begin
      idx = rr + slice_t'(i);
      if (slot_vld[idx]) begin
        pick = idx;
        pick_vld = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= racc_idle;
      slot_vld <= '0;
      rr <= '0;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      raccoon_load_vld <= 1'b0;
    end else begin
      raccoon_load_vld <= 1'b0;
      if (racc_req) begin
        slot_vld[racc_slice] <= 1'b1;
      end
      case (state)
        racc_idle: begin
          if (pick_vld) begin
            state <= racc_bus;
            rr <= pick + slice_t'(1);
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
          end
        end
        // Freeing the slot releases the slice's stall from the next cycle
        racc_bus: begin
          if (wb_ack) begin
            state <= racc_done;
            slot_vld[cur] <= 1'b0;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            raccoon_load_vld <= !wb_we;
          end
        end
        racc_done: begin
          state <= racc_idle;
        end
        default: begin
          state <= racc_idle;
        end
      endcase
    end
  end

  // Bus outputs load once per cycle and stay put until the slave acknowledges
  always_ff @(posedge clk) begin
    if (racc_req) begin
      slot_we[racc_slice] <= racc_we;
      slot_adr[racc_slice] <= racc_adr;
      slot_sel[racc_slice] <= racc_sel;
      slot_wdata[racc_slice] <= racc_wdata;
      slot_rc[racc_slice] <= racc_rc_sel;
    end
    if (state == racc_idle && pick_vld) begin
      cur <= pick;
      wb_we <= slot_we[pick];
      wb_adr <= slot_adr[pick];
      wb_sel <= slot_sel[pick];
      wb_wdata <= slot_wdata[pick];
    end
    if (state == racc_bus && wb_ack) begin
      raccoon_load_slice <= cur;
      raccoon_load_sel <= slot_rc[cur];
      raccoon_load <= wb_rdata;
    end
  end

  assign raccoon_stall = slot_vld;

  assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc && state == racc_bus)
    else $error("wishbone strobe outside a bus cycle");

  // A stalled slice cannot issue, so its slot is always empty when a request comes in
  assert property (@(posedge clk) disable iff (rst) racc_req |-> !slot_vld[racc_slice])
    else $error("bus request for a slice that already has one queued");

endmodule

// File: hdl/tawas_regfile.sv
// Per-slice register banks with operand read ports and AU, load and bridge write ports
`timescale 1ns/1ps

module tawas_regfile import tawas_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  slice_t   slice,
  input  reg_sel_t ra_sel,
  input  reg_sel_t rb_sel,
  input  reg_sel_t ls_ptr_sel,
  input  reg_sel_t ls_store_sel,
  output word_t    au_ra,
  output word_t    au_rb,
  output word_t    ls_ptr,
  output word_t    ls_store,
  input  logic     au_rc_vld,
  input  reg_sel_t au_rc_sel,
  input  word_t    au_rc,
  input  logic     ls_load_vld,
  input  slice_t   ls_load_slice,
  input  reg_sel_t ls_load_sel,
  input  word_t    ls_load,
  input  logic     raccoon_load_vld,
  input  slice_t   raccoon_load_slice,
  input  reg_sel_t raccoon_load_sel,
  input  word_t    raccoon_load
);

  word_t regs [num_slices][num_regs];

  // The AU result arrives one cycle after its operands, so its bank is the previous slice
  slice_t au_slice;

  always_ff @(posedge clk) begin
    au_slice <= slice;
  end

  // Each port writes a different slice in any cycle, so the order here does not matter
  always_ff @(posedge clk) begin
    if (au_rc_vld) begin
      regs[au_slice][au_rc_sel] <= au_rc;
    end
    if (ls_load_vld) begin
      regs[ls_load_slice][ls_load_sel] <= ls_load;
    end
    if (raccoon_load_vld) begin
      regs[raccoon_load_slice][raccoon_load_sel] <= raccoon_load;
    end
  end

  // Reads come from the bank of the slice being decoded and r0 reads zero
  assign au_ra = (ra_sel == '0) ? '0 : regs[slice][ra_sel];
  assign au_rb = (rb_sel == '0) ? '0 : regs[slice][rb_sel];
  assign ls_ptr = (ls_ptr_sel == '0) ? '0 : regs[slice][ls_ptr_sel];
  assign ls_store = (ls_store_sel == '0) ? '0 : regs[slice][ls_store_sel];

  // The pipeline spacing keeps the three write ports on distinct registers
  assert property (@(posedge clk) disable iff (rst)
    !((au_rc_vld && ls_load_vld &&
       au_slice == ls_load_slice && au_rc_sel == ls_load_sel) ||
      (au_rc_vld && raccoon_load_vld &&
       au_slice == raccoon_load_slice && au_rc_sel == raccoon_load_sel) ||
      (ls_load_vld && raccoon_load_vld &&
       ls_load_slice == raccoon_load_slice && ls_load_sel == raccoon_load_sel)))
    else $error("two register writes to one register in the same cycle");

endmodule

// File: src.f
hdl/tawas_pkg.sv
hdl/tawas_fetch.sv
hdl/tawas_regfile.sv
hdl/tawas_au.sv
hdl/tawas_ls.sv
hdl/tawas_raccoon.sv
hdl/tawas.sv
testbench/tawas_tb.sv

// File: testbench/tawas_tb.sv
// Testbench for the tawas core with memory models, Wishbone slave, assembler helpers and tests
`timescale 1ns/1ps

module tawas_tb import tawas_pkg::*; ();

  localparam word_t racc_base = 32'h8000_0000;
  localparam pc_t slice_pc_stride = 24'h40;

  logic clk;
  logic rst;
  logic ics;
  pc_t iaddr;
  word_t idata;
  logic dcs;
  logic dwr;
  mask_t dmask;
  word_t daddr;
  word_t dout;
  word_t din;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  word_t wb_adr;
  mask_t wb_sel;
  word_t wb_wdata;
  word_t wb_rdata;
  logic wb_ack;
  logic [3:0] halted;

  // Instruction, local data and bus memories, all indexed by word
  word_t imem [1024];
  word_t dmem [1024];
  word_t bmem [256];

  // Local writes and bus cycles in the order the memories saw them
  word_t local_addr [$];
  mask_t local_mask [$];
  word_t bus_adr [$];
  logic bus_we [$];
  mask_t bus_sel [$];
  word_t bus_wdata [$];

  int bus_wait;
  logic bus_busy;

  // Master outputs seen in the first cycle of the running bus transfer
  word_t held_adr;
  logic held_we;
  mask_t held_sel;
  word_t held_wdata;

  pc_t load_pc;
  int checks;
  int errors;

  tawas #(
    .racc_base(racc_base),
    .slice_pc_stride(slice_pc_stride)
  ) dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // Instruction memory answers one cycle after the strobe
  always @(posedge clk) begin : imem_model
    word_t iw;
    iw = idata;
    if (ics) begin
      iw = imem[iaddr[9:0]];
    end
    #1;
    idata = iw;
  end

  // Local data memory writes at the strobe edge and returns read data a cycle later
  always @(posedge clk) begin : dmem_model
    word_t rd;
    rd = din;
    if (dcs) begin
      if (dwr) begin
        for (int l = 0; l < 4; l++) begin
          if (dmask[l]) begin
            dmem[daddr[11:2]][8*l +: 8] = dout[8*l +: 8];
          end
        end
        local_addr.push_back(daddr);
        local_mask.push_back(dmask);
      end else begin
        rd = dmem[daddr[11:2]];
      end
    end
    #1;
    din = rd;
  end

  // Wishbone slave with a random number of wait states for every cycle
  always @(posedge clk) begin : wb_model
    logic ack_next;
    word_t rdata_next;
    ack_next = 1'b0;
    rdata_next = wb_rdata;
    if (rst) begin
      bus_busy = 1'b0;
    end else if (wb_cyc && wb_stb && !wb_ack) begin
      if (!bus_busy) begin
        bus_busy = 1'b1;
        bus_wait = $urandom % 5;
        held_adr = wb_adr;
        held_we = wb_we;
        held_sel = wb_sel;
        held_wdata = wb_wdata;
      end else if (wb_adr !== held_adr || wb_we !== held_we || wb_sel !== held_sel ||
                   wb_wdata !== held_wdata) begin
        $display("Wishbone master changed its outputs before ack at %0t", $time);
        errors++;
      end
      if (bus_wait == 0) begin
        ack_next = 1'b1;
        bus_busy = 1'b0;
        if (wb_we) begin
          for (int l = 0; l < 4; l++) begin
            if (wb_sel[l]) begin
              bmem[wb_adr[9:2]][8*l +: 8] = wb_wdata[8*l +: 8];
            end
          end
        end else begin
          rdata_next = bmem[wb_adr[9:2]];
        end
        bus_adr.push_back(wb_adr);
        bus_we.push_back(wb_we);
        bus_sel.push_back(wb_sel);
        bus_wdata.push_back(wb_wdata);
      end else begin
        bus_wait--;
      end
    end
    #1;
    wb_ack = ack_next;
    wb_rdata = rdata_next;
  end

  function automatic word_t rr_instr(opcode_e op, reg_sel_t rc, reg_sel_t ra, reg_sel_t rb);
    return {op, 1'b0, rc, 1'b0, ra, 1'b0, rb, 16'h0000};
  endfunction

  // Covers ADDI, LUI, LD, BZ and JMP, which have no rb field
  function automatic word_t ri_instr(opcode_e op, reg_sel_t rc, reg_sel_t ra, logic [15:0] imm);
    return {op, 1'b0, rc, 1'b0, ra, 4'h0, imm};
  endfunction

  function automatic word_t st_instr(opcode_e op, reg_sel_t ra, reg_sel_t rb, logic [15:0] imm);
    return {op, 1'b0, 3'b000, 1'b0, ra, 1'b0, rb, imm};
  endfunction

  function automatic word_t halt_instr();
    return {op_halt, 28'h0};
  endfunction

  function automatic word_t sext16(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // Every word of a memory gets a value that depends on its full index
  function automatic word_t fill_word(int idx, word_t salt);
    return (word_t'(idx) * 32'h9e37_79b1) ^ salt;
  endfunction

  // Reference model of the register and immediate operations
  function automatic word_t arith_model(opcode_e op, word_t a, word_t b, logic [15:0] imm);
    case (op)
      op_add: return a + b;
      op_sub: return a - b;
      op_and: return a & b;
      op_or: return a | b;
      op_xor: return a ^ b;
      op_addi: return a + sext16(imm);
      op_lui: return {imm, 16'h0000};
      default: return '0;
    endcase
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %0t %s: got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_mask(input string name, input mask_t got, input mask_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %0t %s: got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_halted(input string name, input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %0t %s: got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %0t %s: got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED %0t %s: got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      $display("Wrong number of %s: saw %0d, wanted %0d", what, got, exp);
      errors++;
    end
  endtask

  // Any slice without a program halts at its first fetch
  task automatic init_memories();
    for (int i = 0; i < 1024; i++) begin
      imem[i] = halt_instr();
      dmem[i] = fill_word(i, 32'h5a5a_a5a5);
    end
    for (int i = 0; i < 256; i++) begin
      bmem[i] = fill_word(i, 32'hb0b0_0b0b);
    end
    local_addr.delete();
    local_mask.delete();
    bus_adr.delete();
    bus_we.delete();
    bus_sel.delete();
    bus_wdata.delete();
  endtask

  task automatic start_program(input int s);
    load_pc = pc_t'(s) * slice_pc_stride;
  endtask

  task automatic emit(input word_t w);
    imem[load_pc[9:0]] = w;
    load_pc = load_pc + pc_t'(1);
  endtask

  task automatic reset_dut();
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (5) begin
      @(posedge clk);
      #1;
      check_flag("ics in reset", ics, 1'b0);
      check_flag("dcs in reset", dcs, 1'b0);
      check_flag("wb_cyc in reset", wb_cyc, 1'b0);
      check_halted("halted in reset", halted, 4'h0);
    end
    rst = 1'b0;
  endtask

  task automatic wait_halted(input logic [3:0] mask);
    int cycles;
    cycles = 0;
    while (halted !== mask && cycles < 4000) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (halted !== mask) begin
      $display("Timeout while waiting for halted mask %b, it stayed at %b", mask, halted);
      errors++;
    end
    check_halted("halted", halted, mask);
  endtask

  // Loads two operands from base, stores their sum, xor and r0 after them
  task automatic load_sum_program(input int s, input logic [15:0] base);
    start_program(s);
    emit(ri_instr(op_addi, 5, 0, base));
    emit(ri_instr(op_ld, 1, 5, 16'h0000));
    emit(ri_instr(op_ld, 2, 5, 16'h0004));
    emit(rr_instr(op_add, 3, 1, 2));
    emit(st_instr(op_st, 5, 3, 16'h0008));
    emit(rr_instr(op_xor, 4, 1, 2));
    emit(st_instr(op_st, 5, 4, 16'h000c));
    emit(st_instr(op_st, 5, 0, 16'h0010));
    emit(halt_instr());
    dmem[base[11:2]] = $urandom;
    dmem[base[11:2] + 1] = $urandom;
  endtask

  task automatic check_sum_region(input int s, input logic [15:0] base);
    word_t a;
    word_t b;
    a = dmem[base[11:2]];
    b = dmem[base[11:2] + 1];
    check_word($sformatf("slice %0d sum", s), dmem[base[11:2] + 2], a + b);
    check_word($sformatf("slice %0d xor", s), dmem[base[11:2] + 3], a ^ b);
    check_word($sformatf("slice %0d r0", s), dmem[base[11:2] + 4], 32'h0);
  endtask

  task automatic test_reset();
    init_memories();
    reset_dut();
    // The first four fetch slots walk the slice start addresses in order
    for (int s = 0; s < 4; s++) begin
      @(posedge clk);
      #1;
      check_flag("ics after reset", ics, 1'b1);
      check_pc($sformatf("iaddr of slot %0d", s), iaddr, pc_t'(s) * slice_pc_stride);
    end
    wait_halted(4'hf);
  endtask

  task automatic test_arith();
    opcode_e ops [7];
    logic [15:0] imm;
    word_t a;
    word_t b;
    ops = '{op_add, op_sub, op_and, op_or, op_xor, op_addi, op_lui};
    a = {16'h1234, 16'h0000} + sext16(16'h5678);
    b = {16'hf0f0, 16'h0000} + sext16(16'hfff0);
    init_memories();
    start_program(0);
    emit(ri_instr(op_lui, 1, 0, 16'h1234));
    emit(ri_instr(op_addi, 1, 1, 16'h5678));
    emit(ri_instr(op_lui, 2, 0, 16'hf0f0));
    emit(ri_instr(op_addi, 2, 2, 16'hfff0));
    for (int i = 0; i < 7; i++) begin
      imm = (ops[i] == op_lui) ? 16'hbeef : 16'h8001;
      if (ops[i] == op_addi || ops[i] == op_lui) begin
        emit(ri_instr(ops[i], 3, 1, imm));
      end else begin
        emit(rr_instr(ops[i], 3, 1, 2));
      end
      emit(st_instr(op_st, 0, 3, 16'h0100 + 16'(4 * i)));
    end
    emit(halt_instr());
    reset_dut();
    wait_halted(4'hf);
    for (int i = 0; i < 7; i++) begin
      imm = (ops[i] == op_lui) ? 16'hbeef : 16'h8001;
      check_word($sformatf("%s result", ops[i].name()), dmem[(32'h100 >> 2) + i],
                 arith_model(ops[i], a, b, imm));
    end
  endtask

  task automatic test_load_store();
    word_t w [4];
    word_t packed_bytes;
    word_t exp_addr [8];
    mask_t exp_mask [8];
    exp_addr = '{32'h300, 32'h301, 32'h302, 32'h303, 32'h310, 32'h314, 32'h318, 32'h31c};
    exp_mask = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'hf, 4'hf, 4'hf, 4'hf};
    init_memories();
    start_program(0);
    for (int i = 0; i < 4; i++) begin
      w[i] = $urandom;
      dmem[(32'h200 >> 2) + i] = w[i];
      emit(ri_instr(op_ld, reg_sel_t'(i + 1), 0, 16'h0200 + 16'(4 * i)));
    end
    for (int i = 0; i < 4; i++) begin
      emit(st_instr(op_stb, 0, reg_sel_t'(i + 1), 16'h0300 + 16'(i)));
    end
    for (int i = 0; i < 4; i++) begin
      emit(st_instr(op_st, 0, reg_sel_t'(i + 1), 16'h0310 + 16'(4 * i)));
    end
    emit(halt_instr());
    reset_dut();
    wait_halted(4'hf);
    packed_bytes = {w[3][7:0], w[2][7:0], w[1][7:0], w[0][7:0]};
    check_word("byte lanes at 0x300", dmem[32'h300 >> 2], packed_bytes);
    for (int i = 0; i < 4; i++) begin
      check_word($sformatf("word copy %0d", i), dmem[(32'h310 >> 2) + i], w[i]);
    end
    check_count("local writes", local_addr.size(), 8);
    // The byte stores come first with one lane each, then the word stores with all four
    for (int k = 0; k < 8 && k < local_addr.size(); k++) begin
      check_word($sformatf("daddr of write %0d", k), local_addr[k], exp_addr[k]);
      check_mask($sformatf("dmask of write %0d", k), local_mask[k], exp_mask[k]);
    end
  endtask

  task automatic test_branch();
    int n;
    n = 1 + $urandom % 8;
    init_memories();
    start_program(0);
    emit(ri_instr(op_addi, 1, 0, 16'(n)));
    emit(ri_instr(op_addi, 2, 0, 16'h0400));
    // The loop body starts at word 2 and leaves through BZ once the counter is stored as zero
    emit(st_instr(op_st, 2, 1, 16'h0000));
    emit(ri_instr(op_addi, 2, 2, 16'h0004));
    emit(ri_instr(op_bz, 0, 1, 16'h0003));
    emit(ri_instr(op_addi, 1, 1, 16'hffff));
    emit(ri_instr(op_jmp, 0, 0, 16'h0002));
    emit(ri_instr(op_jmp, 0, 0, 16'h0009));
    emit(st_instr(op_st, 0, 2, 16'h04c0));
    emit(halt_instr());
    reset_dut();
    wait_halted(4'hf);
    for (int k = 0; k <= n; k++) begin
      check_word($sformatf("loop store %0d", k), dmem[(32'h400 >> 2) + k], word_t'(n - k));
    end
    check_word("word past loop", dmem[(32'h400 >> 2) + n + 1],
               fill_word((32'h400 >> 2) + n + 1, 32'h5a5a_a5a5));
    check_word("poison word", dmem[32'h4c0 >> 2], fill_word(32'h4c0 >> 2, 32'h5a5a_a5a5));
    check_count("loop stores", local_addr.size(), n + 1);
  endtask

  task automatic test_interleave();
    init_memories();
    for (int s = 0; s < 4; s++) begin
      load_sum_program(s, 16'h0600 + 16'(s * 'h40));
    end
    reset_dut();
    wait_halted(4'hf);
    for (int s = 0; s < 4; s++) begin
      check_sum_region(s, 16'h0600 + 16'(s * 'h40));
    end
  endtask

  task automatic test_wishbone();
    word_t v;
    word_t lane_word;
    word_t exp_adr [4];
    logic exp_we [4];
    mask_t exp_sel [4];
    v = {16'hcafe, 16'h0000} + sext16(16'h1234);
    exp_adr = '{racc_base + 32'h10, racc_base + 32'h20, racc_base + 32'h31, racc_base + 32'h10};
    exp_we = '{1'b1, 1'b0, 1'b1, 1'b0};
    exp_sel = '{4'hf, 4'hf, 4'h2, 4'hf};
    init_memories();
    start_program(0);
    emit(ri_instr(op_lui, 5, 0, racc_base[31:16]));
    emit(ri_instr(op_lui, 1, 0, 16'hcafe));
    emit(ri_instr(op_addi, 1, 1, 16'h1234));
    emit(st_instr(op_st, 5, 1, 16'h0010));
    emit(ri_instr(op_ld, 2, 5, 16'h0020));
    emit(st_instr(op_st, 0, 2, 16'h0700));
    emit(st_instr(op_stb, 5, 1, 16'h0031));
    emit(ri_instr(op_ld, 3, 5, 16'h0010));
    emit(st_instr(op_st, 0, 3, 16'h0704));
    emit(halt_instr());
    for (int s = 1; s < 4; s++) begin
      load_sum_program(s, 16'h0800 + 16'(s * 'h40));
    end
    reset_dut();
    wait_halted(4'hf);
    check_count("bus cycles", bus_adr.size(), 4);
    for (int k = 0; k < 4 && k < bus_adr.size(); k++) begin
      check_word($sformatf("wb_adr of cycle %0d", k), bus_adr[k], exp_adr[k]);
      check_flag($sformatf("wb_we of cycle %0d", k), bus_we[k], exp_we[k]);
      check_mask($sformatf("wb_sel of cycle %0d", k), bus_sel[k], exp_sel[k]);
    end
    if (bus_adr.size() == 4) begin
      check_word("wb_wdata of word store", bus_wdata[0], v);
      check_word("wb_wdata lane 1 of byte store", word_t'(bus_wdata[2][15:8]),
                 word_t'(v[7:0]));
    end
    lane_word = fill_word(32'h30 >> 2, 32'hb0b0_0b0b);
    lane_word[15:8] = v[7:0];
    check_word("bus word at 0x10", bmem[32'h10 >> 2], v);
    check_word("bus word at 0x30", bmem[32'h30 >> 2], lane_word);
    check_word("bus load copied", dmem[32'h700 >> 2], fill_word(32'h20 >> 2, 32'hb0b0_0b0b));
    check_word("bus reload copied", dmem[32'h704 >> 2], v);
    for (int s = 1; s < 4; s++) begin
      check_sum_region(s, 16'h0800 + 16'(s * 'h40));
    end
  endtask

  initial begin
    rst = 1'b1;
    idata = '0;
    din = '0;
    wb_rdata = '0;
    wb_ack = 1'b0;
    bus_busy = 1'b0;
    bus_wait = 0;
    checks = 0;
    errors = 0;
    void'($urandom(32'hc16f5859));
    test_reset();
    test_arith();
    test_load_store();
    test_branch();
    test_interleave();
    test_wishbone();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
